/* design/cache_perf_monitor.sv */
`timescale 1ns/10ps

module cache_perf_monitor import perf_pkg::*; #(
	parameter logic [31:0] cache_structure   = 32'h0,
	parameter logic [31:0] cache_replacement = 32'h0,
	parameter int          sample_depth      = 4,
	parameter int          buffer_depth      = 8,
	parameter int          sample_period     = 4
) (
	input  logic                 clock_i,
	input  logic                 resetn_i,
	input  logic [31:0]          phase_i,
	input  logic [31:0]          pc_ref_i,
	input  logic [tag_width-1:0] tag_ref_i,
	input  logic                 req_i,
	input  logic                 swap_i,
	input  logic                 hit_i,
	input  logic                 miss_i,
	input  logic                 writeback_i,
	input  logic                 expired_i,
	input  logic                 expired_multi_i,
	input  logic                 defaulted_i,
	input  logic                 rand_evict_i,
	input  logic [31:0]          comm_i,	// configuration word
	input  logic [1:0]           select_data_record_i,
	output logic [31:0]          comm_o,
	output logic                 stall_o
);

	record_src_e  select;
	logic         sampler_en;
	logic [31:0]  pc_bus;
	counter_set_t counters;

	sample_if sample_bus ();

	assign select     = record_src_e'(select_data_record_i);	// 2 and 3 read as stats
	assign sampler_en = (select == rec_sampler);
	assign pc_bus     = {phase_i[31:24], pc_ref_i[23:0]};	// phase tags the pc

	event_counters u_event_counters (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.enable_i        (comm_i[comm_en_bit]),
		.hit_i           (hit_i),
		.miss_i          (miss_i),
		.writeback_i     (writeback_i),
		.expired_i       (expired_i),
		.expired_multi_i (expired_multi_i),
		.defaulted_i     (defaulted_i),
		.rand_evict_i    (rand_evict_i),
		.swap_i          (swap_i),
		.counters_o      (counters)
	);

	reuse_sampler #(
		.sample_depth  (sample_depth),
		.buffer_depth  (buffer_depth),
		.sample_period (sample_period)
	) u_reuse_sampler (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (sampler_en),
		.clear_i  (comm_i[comm_clear_bit]),
		.req_i    (req_i),
		.pc_i     (pc_bus),
		.tag_i    (tag_ref_i),
		.index_i  (comm_i[comm_index_hi:comm_index_lo]),
		.res      (sample_bus.producer)
	);

	stat_readout #(
		.cache_id (cache_structure | cache_replacement)
	) u_stat_readout (
		.clock_i    (clock_i),
		.resetn_i   (resetn_i),
		.select_i   (select),
		.comm_i     (comm_i),
		.counters_i (counters),
		.res        (sample_bus.consumer),
		.comm_o     (comm_o),
		.stall_o    (stall_o)
	);

endmodule

/* design/event_counters.sv */
`timescale 1ns/10ps

module event_counters import perf_pkg::*; (
	input  logic         clock_i,
	input  logic         resetn_i,
	input  logic         enable_i,	// comm bit 24
	input  logic         hit_i,
	input  logic         miss_i,
	input  logic         writeback_i,
	input  logic         expired_i,
	input  logic         expired_multi_i,
	input  logic         defaulted_i,
	input  logic         rand_evict_i,
	input  logic         swap_i,
	output counter_set_t counters_o
);

	counter_set_t cnt_q;
	logic         swap_q;	// swap level on the last enabled cycle
	logic         swap_fall;

	assign swap_fall  = swap_q && !swap_i;	// high to low
	assign counters_o = cnt_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			cnt_q  <= '0;
			swap_q <= 1'b0;
		end else if (enable_i) begin
			if (hit_i) begin
				cnt_q.hit <= cnt_q.hit + 64'd1;
			end
			if (miss_i) begin
				cnt_q.miss <= cnt_q.miss + 64'd1;
			end
			if (writeback_i) begin
				cnt_q.writeback <= cnt_q.writeback + 64'd1;
			end
			if (expired_i) begin
				cnt_q.expired <= cnt_q.expired + 64'd1;
			end
			if (expired_multi_i) begin
				cnt_q.multi_expired <= cnt_q.multi_expired + 64'd1;
			end
			if (defaulted_i) begin
				cnt_q.defaulted <= cnt_q.defaulted + 64'd1;
			end
			if (rand_evict_i) begin
				cnt_q.rand_evict <= cnt_q.rand_evict + 64'd1;
			end
			if (swap_fall) begin
				cnt_q.swap <= cnt_q.swap + 64'd1;
			end
			// edge memory only advances while counting is on
			swap_q     <= swap_i;
			cnt_q.wall <= cnt_q.wall + 64'd1;	// one per enabled cycle
		end
	end

	wall_monotonic: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$past(resetn_i) |-> cnt_q.wall >= $past(cnt_q.wall))
		else $error("wall time counter went backwards");

endmodule

/* design/perf_pkg.sv */
package perf_pkg;

	localparam int tag_width = 20;	// fixed by the cache tag store

	// comm_i field positions
	localparam int comm_en_bit    = 24;	// counting on
	localparam int comm_clear_bit = 25;	// sampler clear
	localparam int comm_index_hi  = 12;
	localparam int comm_index_lo  = 8;
	localparam int comm_addr_hi   = 4;
	localparam int comm_addr_lo   = 0;

	typedef enum logic [1:0] {
		rec_stats   = 2'd0,
		rec_sampler = 2'd1
	} record_src_e;	// codes 2 and 3 fall back to statistics

	typedef enum logic [4:0] {
		st_hit_lo      = 5'd0,
		st_hit_hi      = 5'd1,
		st_miss_lo     = 5'd2,
		st_miss_hi     = 5'd3,
		st_wb_lo       = 5'd4,
		st_wb_hi       = 5'd5,
		st_wall_lo     = 5'd6,
		st_wall_hi     = 5'd7,
		st_expired_lo  = 5'd8,
		st_expired_hi  = 5'd9,
		st_default_lo  = 5'd10,
		st_default_hi  = 5'd11,
		st_mexpired_lo = 5'd12,
		st_mexpired_hi = 5'd13,
		st_cache_id    = 5'd15,
		st_swap_lo     = 5'd16,
		st_swap_hi     = 5'd17,
		st_rand_lo     = 5'd18,
		st_rand_hi     = 5'd19
	} stat_addr_e;

	typedef enum logic [3:0] {
		sm_ref_pc      = 4'd6,
		sm_interval    = 4'd7,
		sm_used        = 4'd8,
		sm_count       = 4'd9,
		sm_remaining   = 4'd10,
		sm_trace_lo    = 4'd11,
		sm_trace_hi    = 4'd12,
		sm_target      = 4'd13,
		sm_buffer_full = 4'd15
	} sampler_addr_e;

	typedef struct packed {
		logic [63:0] hit;
		logic [63:0] miss;
		logic [63:0] writeback;
		logic [63:0] wall;
		logic [63:0] expired;
		logic [63:0] defaulted;
		logic [63:0] multi_expired;
		logic [63:0] swap;
		logic [63:0] rand_evict;
	} counter_set_t;

	// one reuse-interval record in the sampler buffer
	typedef struct packed {
		logic [31:0]          ref_pc;
		logic [tag_width-1:0] tag;
		logic [31:0]          interval;
		logic [63:0]          trace;
	} sample_rec_t;

endpackage

/* design/reuse_sampler.sv */
`timescale 1ns/10ps

module reuse_sampler import perf_pkg::*; #(
	parameter int sample_depth  = 4,	// tag table entries
	parameter int buffer_depth  = 8,	// interval records
	parameter int sample_period = 4	// sample every nth request
) (
	input  logic                 clock_i,
	input  logic                 resetn_i,
	input  logic                 enable_i,
	input  logic                 clear_i,
	input  logic                 req_i,
	input  logic [31:0]          pc_i,
	input  logic [tag_width-1:0] tag_i,
	input  logic [4:0]           index_i,	// record to present
	sample_if.producer           res
);

	localparam int tab_w = (sample_depth > 1) ? $clog2(sample_depth) : 1;
	localparam int buf_w = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;
	localparam int use_w = $clog2(buffer_depth + 1);
	localparam int per_w = $clog2(sample_period + 1);

	logic [sample_depth-1:0] valid_q;
	logic [tag_width-1:0]    tab_tag [sample_depth];
	logic [31:0]             tab_pc [sample_depth];
	logic [31:0]             tab_stamp [sample_depth];	// count at sample time
	sample_rec_t             rec_buf [buffer_depth];
	sample_rec_t             rec_new;
	sample_rec_t             rec_sel;
	logic [use_w-1:0]        used_q;
	logic [31:0]             count_q;
	logic [per_w-1:0]        period_q;	// count modulo sample_period
	logic [tab_w-1:0]        hit_idx;
	logic [tab_w-1:0]        free_idx;
	logic                    hit_found;
	logic                    free_found;
	logic [31:0]             remaining;
	logic                    buffer_full;
	logic                    table_full;
	logic                    accept;
	logic                    do_record;
	logic                    do_store;

	// tag match and first free slot
	always_comb begin
		hit_found  = 1'b0;
		hit_idx    = '0;
		free_found = 1'b0;
		free_idx   = '0;
		remaining  = '0;
		for (int i = 0; i < sample_depth; i++) begin
			if (valid_q[i] && tab_tag[i] == tag_i && !hit_found) begin
				hit_found = 1'b1;
				hit_idx   = tab_w'(i);
			end
			if (!valid_q[i]) begin
				if (!free_found) begin
					free_found = 1'b1;
					free_idx   = tab_w'(i);
				end
				remaining = remaining + 32'd1;
			end
		end
	end

	assign table_full  = !free_found;
	assign buffer_full = (used_q == use_w'(buffer_depth));
	assign accept      = enable_i && req_i && !table_full && !buffer_full;	// stalled otherwise
	assign do_record   = accept && hit_found;
	assign do_store    = accept && !hit_found && (period_q == '0);	// a match is never re-stored

	always_comb begin
		rec_new.ref_pc   = tab_pc[hit_idx];
		rec_new.tag      = tag_i;
		rec_new.interval = count_q - tab_stamp[hit_idx];
		rec_new.trace    = {count_q, tab_stamp[hit_idx]};
	end

	always_ff @(posedge clock_i) begin
		if (!resetn_i || clear_i) begin
			valid_q  <= '0;
			used_q   <= '0;
			count_q  <= '0;
			period_q <= '0;
		end else if (accept) begin
			count_q  <= count_q + 32'd1;
			period_q <= (period_q == per_w'(sample_period - 1)) ? '0 : period_q + per_w'(1);
			if (do_record) begin
				valid_q[hit_idx] <= 1'b0;	// entry is done once reused
				used_q           <= used_q + use_w'(1);
			end else if (do_store) begin
				valid_q[free_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (do_store) begin
			tab_tag[free_idx]   <= tag_i;
			tab_pc[free_idx]    <= pc_i;
			tab_stamp[free_idx] <= count_q;
		end
		if (do_record) begin
			rec_buf[used_q[buf_w-1:0]] <= rec_new;
		end
	end

	// slots past used read as zero
	always_comb begin
		rec_sel = '0;
		if (32'(index_i) < 32'(used_q)) begin
			rec_sel = rec_buf[index_i[buf_w-1:0]];
		end
	end

	assign res.ref_pc      = rec_sel.ref_pc;
	assign res.target_tag  = rec_sel.tag;
	assign res.interval    = rec_sel.interval;
	assign res.trace       = rec_sel.trace;
	assign res.used        = 32'(used_q);
	assign res.count       = count_q;
	assign res.remaining   = remaining;
	assign res.buffer_full = buffer_full;
	assign res.table_full  = table_full;

	used_bounded: assert property (@(posedge clock_i) disable iff (!resetn_i)
		used_q <= use_w'(buffer_depth))
		else $error("record count beyond buffer depth");

	no_write_when_full: assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_full && !clear_i |=> used_q == $past(used_q))
		else $error("record written into a full buffer");

endmodule

/* design/sample_if.sv */
`timescale 1ns/10ps

interface sample_if import perf_pkg::*; ();

	logic [31:0]          ref_pc;	// pc of the selected record
	logic [tag_width-1:0] target_tag;
	logic [31:0]          interval;
	logic [63:0]          trace;	// sample count low, reuse count high
	logic [31:0]          used;	// records in the buffer
	logic [31:0]          count;	// requests since reset or clear
	logic [31:0]          remaining;	// free table slots
	logic                 buffer_full;
	logic                 table_full;

	modport producer (
		output ref_pc,
		output target_tag,
		output interval,
		output trace,
		output used,
		output count,
		output remaining,
		output buffer_full,
		output table_full
	);

	modport consumer (
		input ref_pc,
		input target_tag,
		input interval,
		input trace,
		input used,
		input count,
		input remaining,
		input buffer_full,
		input table_full
	);

endinterface

/* design/stat_readout.sv */
`timescale 1ns/10ps

module stat_readout import perf_pkg::*; #(
	parameter logic [31:0] cache_id = 32'h0
) (
	input  logic         clock_i,
	input  logic         resetn_i,
	input  record_src_e  select_i,
	input  logic [31:0]  comm_i,
	input  counter_set_t counters_i,
	sample_if.consumer   res,
	output logic [31:0]  comm_o,
	output logic         stall_o
);

	stat_addr_e    stat_addr;
	sampler_addr_e samp_addr;
	logic [31:0]   stat_q;	// statistics word
	logic [31:0]   samp_q;	// sampler word
	record_src_e   sel_q;	// source of the registered words

	assign stat_addr = stat_addr_e'(comm_i[comm_addr_hi:comm_addr_lo]);
	assign samp_addr = sampler_addr_e'(comm_i[comm_addr_lo +: 4]);

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			stat_q <= '0;
			samp_q <= '0;
			sel_q  <= rec_stats;
		end else begin
			sel_q <= select_i;
			case (stat_addr)
				st_hit_lo:      stat_q <= counters_i.hit[31:0];
				st_hit_hi:      stat_q <= counters_i.hit[63:32];
				st_miss_lo:     stat_q <= counters_i.miss[31:0];
				st_miss_hi:     stat_q <= counters_i.miss[63:32];
				st_wb_lo:       stat_q <= counters_i.writeback[31:0];
				st_wb_hi:       stat_q <= counters_i.writeback[63:32];
				st_wall_lo:     stat_q <= counters_i.wall[31:0];	// enabled cycles
				st_wall_hi:     stat_q <= counters_i.wall[63:32];
				st_expired_lo:  stat_q <= counters_i.expired[31:0];
				st_expired_hi:  stat_q <= counters_i.expired[63:32];
				st_default_lo:  stat_q <= counters_i.defaulted[31:0];
				st_default_hi:  stat_q <= counters_i.defaulted[63:32];
				st_mexpired_lo: stat_q <= counters_i.multi_expired[31:0];
				st_mexpired_hi: stat_q <= counters_i.multi_expired[63:32];
				st_cache_id:    stat_q <= cache_id;
				st_swap_lo:     stat_q <= counters_i.swap[31:0];
				st_swap_hi:     stat_q <= counters_i.swap[63:32];
				st_rand_lo:     stat_q <= counters_i.rand_evict[31:0];
				st_rand_hi:     stat_q <= counters_i.rand_evict[63:32];
				default:        stat_q <= '0;
			endcase
			case (samp_addr)
				sm_ref_pc:      samp_q <= res.ref_pc;
				sm_interval:    samp_q <= res.interval;
				sm_used:        samp_q <= res.used;
				sm_count:       samp_q <= res.count;
				sm_remaining:   samp_q <= res.remaining;
				sm_trace_lo:    samp_q <= res.trace[31:0];
				sm_trace_hi:    samp_q <= res.trace[63:32];
				sm_target:      samp_q <= 32'(res.target_tag);
				sm_buffer_full: samp_q <= {31'b0, res.buffer_full};
				default:        samp_q <= '0;
			endcase
		end
	end

	// select is registered with the words so a source change also takes one cycle
	assign comm_o = (sel_q == rec_sampler) ? samp_q : stat_q;

	assign stall_o = (select_i == rec_sampler) && (res.buffer_full || res.table_full);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_cache_perf_monitor \
	-o sim_tb_cache_perf_monitor \
	&& ./obj_dir/sim_tb_cache_perf_monitor | tee /dev/stderr | grep -q "PASS: all tests" \
	&& echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }

/* src.f */
design/perf_pkg.sv
design/sample_if.sv
design/event_counters.sv
design/reuse_sampler.sv
design/stat_readout.sv
design/cache_perf_monitor.sv
tests/tb_cache_perf_monitor.sv

/* tests/tb_cache_perf_monitor.sv */
`timescale 1ns/10ps

module tb_cache_perf_monitor import perf_pkg::*;;

	localparam logic [31:0] structure_id   = 32'h0012_0400;
	localparam logic [31:0] replacement_id = 32'h0000_0003;
	localparam int          sample_depth   = 4;
	localparam int          buffer_depth   = 8;
	localparam int          sample_period  = 4;
	localparam int          n_cycles       = 60;	// enabled strobe cycles

	logic clock_i, resetn_i, req_i, swap_i, stall_o;
	logic hit_i, miss_i, writeback_i, expired_i, expired_multi_i, defaulted_i, rand_evict_i;
	logic [31:0] phase_i, pc_ref_i, comm_i, comm_o;
	logic [tag_width-1:0] tag_ref_i;
	logic [1:0] select_data_record_i;

	int errors, tests, failed, err_mark;
	logic [63:0] cnt [9];	// hit miss wb wall expired defaulted mexp swap rand
	logic        swap_prev;
	logic [31:0] rd_word [$];	// read table of comm words, selects and expected values
	logic [1:0]  rd_sel [$];
	logic [31:0] rd_exp [$];
	logic                 m_valid [sample_depth];
	logic [tag_width-1:0] m_tag [sample_depth];
	logic [31:0]          m_pc [sample_depth];
	logic [31:0]          m_stamp [sample_depth];
	logic [31:0]          m_count, m_used;
	logic [31:0]          r_pc [buffer_depth];
	logic [tag_width-1:0] r_tag [buffer_depth];
	logic [31:0]          r_int [buffer_depth];
	logic [31:0]          r_lo [buffer_depth];
	logic [31:0]          r_hi [buffer_depth];

	cache_perf_monitor #(
		.cache_structure   (structure_id),
		.cache_replacement (replacement_id),
		.sample_depth      (sample_depth),
		.buffer_depth      (buffer_depth),
		.sample_period     (sample_period)
	) u_cache_perf_monitor (.*);

	initial begin
		clock_i = 1'b0;
		forever #10 clock_i = ~clock_i;
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic add_read(input logic [1:0] sel, input logic [31:0] cw, input logic [31:0] exp);
		rd_sel.push_back(sel);
		rd_word.push_back(cw);
		rd_exp.push_back(exp);
	endtask

	// one cycle of latency from comm_i to comm_o
	task automatic apply_reads();
		for (int i = 0; i < rd_word.size(); i++) begin
			@(posedge clock_i);
			select_data_record_i <= rd_sel[i];
			comm_i               <= rd_word[i];
			@(posedge clock_i);
			@(negedge clock_i);
			check_value($sformatf("comm_o[word %h]", rd_word[i]), comm_o, rd_exp[i]);
		end
		rd_sel.delete();
		rd_word.delete();
		rd_exp.delete();
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != err_mark) failed++;
		$display("test %0d %s: %s", tests, name, (errors != err_mark) ? "failed" : "ok");
		err_mark = errors;
	endtask

	// sampler reference model for one request
	task automatic model_request(input logic [tag_width-1:0] tag, input logic [31:0] pcw);
		int hit, free, nfree;
		hit = -1;
		free = -1;
		nfree = 0;
		for (int i = 0; i < sample_depth; i++) begin
			if (m_valid[i] && m_tag[i] == tag && hit < 0) hit = i;
			if (!m_valid[i]) begin
				nfree++;
				if (free < 0) free = i;
			end
		end
		if (nfree == 0 || m_used == buffer_depth) return;	// stalled
		if (hit >= 0) begin
			r_pc[m_used]  = m_pc[hit];
			r_tag[m_used] = tag;
			r_int[m_used] = m_count - m_stamp[hit];
			r_lo[m_used]  = m_stamp[hit];
			r_hi[m_used]  = m_count;
			m_valid[hit]  = 1'b0;
			m_used++;
		end else if (m_count % sample_period == 0) begin
			m_valid[free] = 1'b1;
			m_tag[free]   = tag;
			m_pc[free]    = pcw;
			m_stamp[free] = m_count;
		end
		m_count++;
	endtask

	function automatic logic [31:0] model_free();
		logic [31:0] n;
		n = 0;
		for (int i = 0; i < sample_depth; i++) if (!m_valid[i]) n++;
		return n;
	endfunction

	task automatic wait_stall(input logic [tag_width-1:0] base, input logic step);
		int k;
		k = 0;
		@(negedge clock_i);
		while (!stall_o && k < 100) begin
			@(posedge clock_i);
			req_i     <= 1'b1;
			tag_ref_i <= step ? base + tag_width'(k) : base;
			@(negedge clock_i);
			k++;
		end
		if (!stall_o) begin
			$display("Error at %0t ns: stall_o never rose within 100 requests", $time);
			errors++;
		end
		@(posedge clock_i);
		req_i <= 1'b0;
	endtask

	initial begin
		logic [31:0] r, pcw;
		logic [tag_width-1:0] seq_tag [6];
		r = $urandom(32'he1f7_1653);
		{req_i, swap_i, hit_i, miss_i, writeback_i, expired_i} = '0;
		{expired_multi_i, defaulted_i, rand_evict_i} = '0;
		{phase_i, pc_ref_i, comm_i, tag_ref_i, select_data_record_i} = '0;
		{errors, tests, failed, err_mark} = '0;
		resetn_i = 1'b0;
		for (int i = 0; i < 9; i++) cnt[i] = '0;
		swap_prev = 1'b0;
		for (int i = 0; i < sample_depth; i++) m_valid[i] = 1'b0;
		m_count = '0;
		m_used  = '0;
		repeat (16) @(posedge clock_i);
		resetn_i <= 1'b1;

		for (int a = 0; a < 32; a++) begin
			add_read(2'd0, 32'(a), (a == 15) ? structure_id | replacement_id : 32'd0);
		end
		apply_reads();
		@(posedge clock_i);
		select_data_record_i <= 2'd1;	// flags are visible on stall_o only in sampler mode
		@(negedge clock_i);
		check_value("stall_o", 32'(stall_o), 0);
		end_test("reset values");

		for (int c = 0; c < n_cycles + 10; c++) begin
			@(posedge clock_i);
			r = $urandom();
			{hit_i, miss_i, writeback_i, expired_i} <= r[3:0];
			{expired_multi_i, defaulted_i, rand_evict_i, swap_i} <= r[7:4];
			comm_i <= (c < n_cycles) ? 32'h0100_0000 : 32'h0;	// last ten cycles disabled
			if (c < n_cycles) begin
				cnt[0] += 64'(r[3]);
				cnt[1] += 64'(r[2]);
				cnt[2] += 64'(r[1]);
				cnt[3] += 1;
				cnt[4] += 64'(r[0]);
				cnt[5] += 64'(r[6]);
				cnt[6] += 64'(r[7]);
				cnt[7] += 64'(swap_prev && !r[4]);
				cnt[8] += 64'(r[5]);
				swap_prev = r[4];
			end
		end
		@(posedge clock_i);
		{hit_i, miss_i, writeback_i, expired_i, expired_multi_i, defaulted_i, rand_evict_i} <= '0;
		swap_i <= 1'b0;
		for (int i = 0; i < 7; i++) begin
			add_read(2'd0, 32'(2 * i), cnt[i][31:0]);
			add_read(2'd0, 32'(2 * i + 1), cnt[i][63:32]);
		end
		add_read(2'd0, 32'd18, cnt[8][31:0]);
		add_read(2'd0, 32'd19, cnt[8][63:32]);
		apply_reads();
		end_test("event counters");

		add_read(2'd0, 32'd16, cnt[7][31:0]);
		add_read(2'd0, 32'd17, cnt[7][63:32]);
		add_read(2'd3, 32'd15, structure_id | replacement_id);	// code 3 reads statistics
		add_read(2'd0, 32'd14, 0);
		add_read(2'd0, 32'd25, 0);
		apply_reads();
		end_test("swap count and cache id");

		seq_tag = '{20'h0_A11A, 20'h0_B22B, 20'h0_C33C, 20'h0_D44D, 20'h0_A11A, 20'h0_E55E};
		for (int s = 0; s < 6; s++) begin
			@(posedge clock_i);
			select_data_record_i <= 2'd1;
			comm_i    <= 32'h0;
			req_i     <= 1'b1;
			tag_ref_i <= seq_tag[s];
			phase_i   <= 32'h5A00_0000 + 32'(s);
			pc_ref_i  <= 32'h7F10_0000 + 32'(16 * s);
			pcw = {8'h5A, 24'h10_0000 + 24'(16 * s)};	// phase high byte over pc
			model_request(seq_tag[s], pcw);
		end
		@(posedge clock_i);
		req_i <= 1'b0;
		add_read(2'd1, 32'd6, r_pc[0]);
		add_read(2'd1, 32'd7, r_int[0]);
		add_read(2'd1, 32'd13, 32'(r_tag[0]));
		add_read(2'd1, 32'd11, r_lo[0]);
		add_read(2'd1, 32'd12, r_hi[0]);
		add_read(2'd1, 32'd8, m_used);
		add_read(2'd1, 32'd9, m_count);
		add_read(2'd1, 32'd10, model_free());
		add_read(2'd1, 32'h0000_0106, 0);	// record 1 not written yet
		apply_reads();
		end_test("reuse sample");

		wait_stall(20'h1_0000, 1'b1);	// distinct tags fill the table
		@(negedge clock_i);
		check_value("stall_o", 32'(stall_o), 1);
		add_read(2'd1, 32'd10, 0);
		apply_reads();
		@(posedge clock_i);
		select_data_record_i <= 2'd0;
		@(negedge clock_i);
		check_value("stall_o", 32'(stall_o), 0);
		@(posedge clock_i);
		select_data_record_i <= 2'd1;
		comm_i <= 32'h0200_0000;	// clear
		@(posedge clock_i);
		comm_i <= 32'h0;
		wait_stall(20'h2_0000, 1'b0);	// one tag reused until the buffer fills
		add_read(2'd1, 32'd15, 1);
		add_read(2'd1, 32'd8, buffer_depth);
		apply_reads();
		@(posedge clock_i);
		comm_i <= 32'h0200_0000;
		@(posedge clock_i);
		comm_i <= 32'h0;
		@(negedge clock_i);
		check_value("stall_o", 32'(stall_o), 0);
		add_read(2'd1, 32'd8, 0);
		add_read(2'd1, 32'd9, 0);
		apply_reads();
		end_test("stall and clear");

		$display("tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
